// File: common/cache_fabric_pkg.sv
package cache_fabric_pkg;

  // Fabric sizing
  localparam int NUM_PORTS      = 4;
  localparam int NUM_REQUESTERS = NUM_PORTS + 1;  // Core ports plus prefetcher
  localparam int PF_SRC         = NUM_PORTS;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SRC_W  = 3;

  localparam int PORT_DEPTH  = 4;  // Also the core credits per port
  localparam int MEM_CREDITS = 4;

  // Derived widths
  localparam int PORT_PTR_W   = $clog2(PORT_DEPTH);
  localparam int PORT_CNT_W   = $clog2(PORT_DEPTH + 1);
  localparam int REQ_IDX_W    = $clog2(NUM_REQUESTERS);
  localparam int MEM_CREDIT_W = $clog2(MEM_CREDITS + 1);

  // Core to port
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } core_req_t;

  // Port to core
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } core_rsp_t;

  // Arbiter inputs and the memory request channel
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [SRC_W-1:0]  src;
  } mem_req_t;

  // Memory response, broadcast to every port
  typedef struct packed {
    logic              valid;
    logic [SRC_W-1:0]  src;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

  // Prefetcher configuration, the set strobes load base and stride
  typedef struct packed {
    logic              base_set;
    logic [ADDR_W-1:0] base;
    logic              stride_set;
    logic [ADDR_W-1:0] stride;
    logic              enable;
  } pf_cfg_t;

endpackage

// File: filelist.f
common/cache_fabric_pkg.sv
hw/req_port/req_port.sv
hw/mem_arbiter.sv
hw/stride_prefetcher.sv
hw/cache_req_fabric.sv
testbench/cache_req_fabric_sva.sv
testbench/tb_cache_req_fabric.sv

// File: hw/cache_req_fabric.sv
`timescale 1ns/1ns

module cache_req_fabric (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  cache_fabric_pkg::core_req_t         core_req_i [cache_fabric_pkg::NUM_PORTS],
  input  cache_fabric_pkg::pf_cfg_t           pf_cfg_i,
  input  logic                                mem_credit_i,
  input  cache_fabric_pkg::mem_rsp_t          mem_rsp_i,
  output logic                                core_credit_o [cache_fabric_pkg::NUM_PORTS],
  output cache_fabric_pkg::core_rsp_t         core_rsp_o [cache_fabric_pkg::NUM_PORTS],
  output cache_fabric_pkg::mem_req_t          mem_req_o,
  output logic [cache_fabric_pkg::ADDR_W-1:0] pf_base_o,
  output logic [cache_fabric_pkg::ADDR_W-1:0] pf_stride_o,
  output logic [15:0]                         pf_count_o
);

  import cache_fabric_pkg::*;

  // Arbiter slots 0..NUM_PORTS-1 are the core ports, PF_SRC is the prefetcher
  mem_req_t                  arb_req [NUM_REQUESTERS];
  logic [NUM_REQUESTERS-1:0] arb_grant;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    req_port #(
      .SrcId         (p)
    ) i_req_port (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .core_req_i    (core_req_i[p]),
      .grant_i       (arb_grant[p]),
      .mem_rsp_i     (mem_rsp_i),
      .head_o        (arb_req[p]),
      .core_credit_o (core_credit_o[p]),
      .core_rsp_o    (core_rsp_o[p])
    );
  end

  stride_prefetcher i_stride_prefetcher (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_i      (pf_cfg_i),
    .snoop_i    (mem_req_o),  // Watches what actually went to memory
    .grant_i    (arb_grant[PF_SRC]),
    .pf_req_o   (arb_req[PF_SRC]),
    .base_o     (pf_base_o),
    .stride_o   (pf_stride_o),
    .pf_count_o (pf_count_o)
  );

  mem_arbiter i_mem_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (arb_req),
    .mem_credit_i (mem_credit_i),
    .grant_o      (arb_grant),
    .mem_req_o    (mem_req_o)
  );

endmodule

// File: hw/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  cache_fabric_pkg::mem_req_t                  req_i [cache_fabric_pkg::NUM_REQUESTERS],
  input  logic                                        mem_credit_i,
  output logic [cache_fabric_pkg::NUM_REQUESTERS-1:0] grant_o,
  output cache_fabric_pkg::mem_req_t                  mem_req_o
);

  import cache_fabric_pkg::*;

  logic [REQ_IDX_W-1:0]    rr_ptr_q;  // First requester to look at
  logic [REQ_IDX_W-1:0]    win_idx;
  logic                    win_found;
  logic                    issue;

  logic [MEM_CREDIT_W-1:0] credit_q;
  logic [MEM_CREDIT_W-1:0] credit_d;

  logic                    out_valid_q;
  logic                    out_write_q;
  logic [ADDR_W-1:0]       out_addr_q;
  logic [DATA_W-1:0]       out_wdata_q;
  logic [SRC_W-1:0]        out_src_q;

  // Round-robin search starting at the pointer
  always_comb begin
    int idx;
    win_found = 1'b0;
    win_idx   = '0;
    for (int i = 0; i < NUM_REQUESTERS; i++) begin
      idx = int'(rr_ptr_q) + i;
      if (idx >= NUM_REQUESTERS) idx = idx - NUM_REQUESTERS;
      if (!win_found && req_i[idx].valid) begin
        win_found = 1'b1;
        win_idx   = REQ_IDX_W'(idx);
      end
    end
  end

  assign issue = win_found && (credit_q != '0);  // Nothing goes out without a credit

  always_comb begin
    grant_o = '0;
    if (issue) grant_o[win_idx] = 1'b1;
  end

  // Credit counter, saturates at the reset value
  always_comb begin
    credit_d = credit_q;
    if (issue) credit_d = credit_d - 1'b1;
    if (mem_credit_i && (credit_d != MEM_CREDIT_W'(MEM_CREDITS))) begin
      credit_d = credit_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q    <= MEM_CREDIT_W'(MEM_CREDITS);
      rr_ptr_q    <= '0;
      out_valid_q <= 1'b0;
    end else begin
      credit_q    <= credit_d;
      out_valid_q <= issue;
      if (issue) begin
        rr_ptr_q <= (win_idx == REQ_IDX_W'(NUM_REQUESTERS - 1)) ? '0 : win_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      out_write_q <= req_i[win_idx].write;
      out_addr_q  <= req_i[win_idx].addr;
      out_wdata_q <= req_i[win_idx].wdata;
      out_src_q   <= req_i[win_idx].src;
    end
  end

  assign mem_req_o.valid = out_valid_q;
  assign mem_req_o.write = out_write_q;
  assign mem_req_o.addr  = out_addr_q;
  assign mem_req_o.wdata = out_wdata_q;
  assign mem_req_o.src   = out_src_q;

endmodule

// File: hw/req_port/req_port.sv
`timescale 1ns/1ns

module req_port #(
  parameter int unsigned SrcId = 0
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  cache_fabric_pkg::core_req_t core_req_i,
  input  logic                        grant_i,
  input  cache_fabric_pkg::mem_rsp_t  mem_rsp_i,
  output cache_fabric_pkg::mem_req_t  head_o,
  output logic                        core_credit_o,
  output cache_fabric_pkg::core_rsp_t core_rsp_o
);

  import cache_fabric_pkg::*;

  // Queue storage
  logic                  q_write [PORT_DEPTH];
  logic [ADDR_W-1:0]     q_addr  [PORT_DEPTH];
  logic [DATA_W-1:0]     q_wdata [PORT_DEPTH];

  logic [PORT_PTR_W-1:0] wr_ptr_q;
  logic [PORT_PTR_W-1:0] rd_ptr_q;
  logic [PORT_CNT_W-1:0] count_q;
  logic                  push;
  logic                  pop;

  logic                  rsp_valid_q;
  logic [DATA_W-1:0]     rsp_rdata_q;

  function automatic logic [PORT_PTR_W-1:0] ptr_inc(input logic [PORT_PTR_W-1:0] ptr);
    if (ptr == PORT_PTR_W'(PORT_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push = core_req_i.valid;  // Core never sends without a credit
  assign pop  = grant_i && (count_q != '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      q_write[wr_ptr_q] <= core_req_i.write;
      q_addr[wr_ptr_q]  <= core_req_i.addr;
      q_wdata[wr_ptr_q] <= core_req_i.wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Idle, or push and pop together
      endcase
    end
  end

  // Head entry as seen by the arbiter, stamped with our source number
  always_comb begin
    head_o.valid = (count_q != '0);
    head_o.write = q_write[rd_ptr_q];
    head_o.addr  = q_addr[rd_ptr_q];
    head_o.wdata = q_wdata[rd_ptr_q];
    head_o.src   = SRC_W'(SrcId);
  end

  // One credit back per entry that leaves
  assign core_credit_o = pop;

  // Pick out our own responses from the broadcast
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= mem_rsp_i.valid && (mem_rsp_i.src == SRC_W'(SrcId));
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rsp_i.valid && (mem_rsp_i.src == SRC_W'(SrcId))) begin
      rsp_rdata_q <= mem_rsp_i.rdata;
    end
  end

  assign core_rsp_o.valid = rsp_valid_q;
  assign core_rsp_o.rdata = rsp_rdata_q;

endmodule

// File: hw/stride_prefetcher.sv
`timescale 1ns/1ns

module stride_prefetcher (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  cache_fabric_pkg::pf_cfg_t           cfg_i,
  input  cache_fabric_pkg::mem_req_t          snoop_i,
  input  logic                                grant_i,
  output cache_fabric_pkg::mem_req_t          pf_req_o,
  output logic [cache_fabric_pkg::ADDR_W-1:0] base_o,
  output logic [cache_fabric_pkg::ADDR_W-1:0] stride_o,
  output logic [15:0]                         pf_count_o
);

  import cache_fabric_pkg::*;

  logic [ADDR_W-1:0] base_q;
  logic [ADDR_W-1:0] stride_q;
  logic [ADDR_W-1:0] next_addr;
  logic [15:0]       count_q;

  logic              pf_valid_q;
  logic [ADDR_W-1:0] pf_addr_q;
  logic              trigger;
  logic              taken;

  assign next_addr = base_q + stride_q;

  // Load from port 0 that hits the base, one pending prefetch at a time
  assign trigger = cfg_i.enable && !pf_valid_q
                && snoop_i.valid && !snoop_i.write
                && (snoop_i.src == SRC_W'(0))
                && (snoop_i.addr == base_q);

  assign taken = grant_i && pf_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q     <= '0;
      stride_q   <= '0;
      count_q    <= '0;
      pf_valid_q <= 1'b0;
    end else begin
      if (cfg_i.stride_set) stride_q <= cfg_i.stride;

      if (cfg_i.base_set) begin
        base_q <= cfg_i.base;  // Software write wins over the advance
      end else if (taken) begin
        base_q <= next_addr;
      end

      if (taken) begin
        pf_valid_q <= 1'b0;
        count_q    <= count_q + 1'b1;
      end else if (trigger) begin
        pf_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (trigger) pf_addr_q <= next_addr;
  end

  // Read only, on the prefetcher's own source slot
  always_comb begin
    pf_req_o.valid = pf_valid_q;
    pf_req_o.write = 1'b0;
    pf_req_o.addr  = pf_addr_q;
    pf_req_o.wdata = '0;
    pf_req_o.src   = SRC_W'(PF_SRC);
  end

  assign base_o     = base_q;
  assign stride_o   = stride_q;
  assign pf_count_o = count_q;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cache request fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module tb_cache_req_fabric \
  -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG_FILE"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi

// File: testbench/cache_req_fabric_sva.sv
`timescale 1ns/1ns

module cache_req_fabric_sva #(
  parameter bit ArbSide = 1'b0
) (
  input logic                                      clk_i,
  input logic                                      rst_ni,
  input logic                                      granted_i,
  input logic                                      credit_pulse_i,
  input logic                                      credit_ret_i,
  input logic [cache_fabric_pkg::MEM_CREDIT_W-1:0] credit_cnt_i
);

  import cache_fabric_pkg::*;

  if (ArbSide) begin : gen_arb
    // granted_i is the issue as seen on the memory channel
    no_issue_without_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      granted_i |-> ($past(credit_cnt_i) != '0))
      else $error("Arbiter issued a request with no memory credit");

    issue_uses_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      granted_i && !$past(credit_ret_i) |->
        (int'(credit_cnt_i) + 1 == int'($past(credit_cnt_i))))
      else $error("Issue did not take exactly one memory credit");

    credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
      credit_cnt_i <= MEM_CREDIT_W'(MEM_CREDITS))
      else $error("Memory credit count above its reset value");
  end else begin : gen_port
    // Every grant pops an entry and every pop answers a grant
    credit_on_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
      credit_pulse_i == granted_i)
      else $error("Core credit pulse does not match the grant");
  end

endmodule

bind mem_arbiter cache_req_fabric_sva #(.ArbSide(1'b1)) i_arb_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .granted_i      (mem_req_o.valid),
  .credit_pulse_i (1'b0),
  .credit_ret_i   (mem_credit_i),
  .credit_cnt_i   (credit_q)
);

bind req_port cache_req_fabric_sva #(.ArbSide(1'b0)) i_port_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .granted_i      (grant_i),
  .credit_pulse_i (core_credit_o),
  .credit_ret_i   (1'b0),
  .credit_cnt_i   ('0)
);

// File: testbench/fabric_testdata.txt
# name port write addr(hex) data(hex) expected(hex)
# Prefetch lines are loads on port 0, base in addr and stride in data
wr_rd_p0 0 1 00000100 a5a50001 00000000
wr_rd_p0 0 0 00000100 00000000 a5a50001
wr_rd_p1 1 1 00000200 12345678 00000000
wr_rd_p1 1 0 00000200 00000000 12345678
cross_port 2 1 00000300 cafe0003 00000000
cross_port 3 0 00000300 00000000 cafe0003
overwrite 3 1 00000300 beef0004 00000000
overwrite 1 0 00000300 00000000 beef0004
unwritten 2 0 00000400 00000000 00000000
burst 1 1 00000500 00000051 00000000
burst 1 1 00000504 00000052 00000000
burst 1 1 00000508 00000053 00000000
burst 1 0 00000504 00000000 00000052
credit_hold 0 1 00000600 00000060 00000000
credit_hold 1 1 00000610 00000061 00000000
credit_hold 2 1 00000620 00000062 00000000
credit_hold 3 0 00000100 00000000 a5a50001
credit_hold 0 0 00000200 00000000 12345678
credit_hold 1 0 00000300 00000000 beef0004
credit_hold 2 0 00000504 00000000 00000052
credit_hold 3 1 00000630 00000063 00000000
prefetch 0 0 00001000 00000040 00000000
prefetch_off 0 0 00002000 00000010 00000000

// File: testbench/tb_cache_req_fabric.sv
`timescale 1ns/1ns

module tb_cache_req_fabric;

  import cache_fabric_pkg::*;

  localparam int MAX_OPS     = 64;
  localparam int WAIT_LIMIT  = 2000;  // Cycles per wait loop
  localparam int HOLD_WINDOW = 20;
  localparam int SIM_CYCLES  = 200_000;  // Overall limit on the run

  logic      clk_i = 1'b0;
  logic      rst_ni;
  core_req_t core_req [NUM_PORTS];
  pf_cfg_t   pf_cfg;
  logic      mem_credit;
  mem_rsp_t  mem_rsp;
  logic      core_credit [NUM_PORTS];
  core_rsp_t core_rsp [NUM_PORTS];
  mem_req_t  mem_req;
  logic [ADDR_W-1:0] pf_base;
  logic [ADDR_W-1:0] pf_stride;
  logic [15:0]       pf_count;

  // Operations from the data file
  string             op_name [MAX_OPS];
  int                op_port [MAX_OPS];
  int                op_write [MAX_OPS];
  logic [31:0]       op_addr [MAX_OPS];
  logic [31:0]       op_data [MAX_OPS];
  logic [31:0]       op_exp [MAX_OPS];
  int                num_ops;

  // Bookkeeping shared by the memory model and the tests
  int                cyc;
  bit                hold_credits;
  int                credits [NUM_PORTS];
  int                credit_pulses [NUM_PORTS];
  int                rsp_cnt [NUM_PORTS];
  logic [31:0]       last_rsp [NUM_PORTS];
  int                issued_src [NUM_REQUESTERS];
  int                sent [NUM_PORTS];
  int                total_sent;
  int                total_core_issued;
  logic [31:0]       pf_last_addr;
  logic              pf_last_write;
  logic [31:0]       mem_model [logic [31:0]];
  int                credit_due [$];
  int                rsp_due [$];
  mem_rsp_t          rsp_q [$];
  int                seed = 32'h2d5d_7ea4;
  int                errors;
  int                tests_run;
  int                tests_failed;
  bit                timed_out;
  string             timeout_what;

  // Expected responses of the running test
  int                rsp_base [NUM_PORTS];
  int                exp_reads [NUM_PORTS];
  logic [31:0]       exp_last [NUM_PORTS];

  cache_req_fabric UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .core_req_i    (core_req),
    .pf_cfg_i      (pf_cfg),
    .mem_credit_i  (mem_credit),
    .mem_rsp_i     (mem_rsp),
    .core_credit_o (core_credit),
    .core_rsp_o    (core_rsp),
    .mem_req_o     (mem_req),
    .pf_base_o     (pf_base),
    .pf_stride_o   (pf_stride),
    .pf_count_o    (pf_count)
  );

  always #50 clk_i = ~clk_i;

  function automatic int rand_delay();
    return 1 + int'($unsigned($random(seed)) % 32'd4);  // 1 to 4 cycles
  endfunction

  // Memory model, samples the DUT just after the edge and drives for the next one
  always @(posedge clk_i) begin
    mem_rsp_t entry;
    #1;
    cyc++;
    if (rst_ni) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (core_credit[p]) begin
          credits[p]++;
          credit_pulses[p]++;
        end
        if (core_rsp[p].valid) begin
          rsp_cnt[p]++;
          last_rsp[p] = core_rsp[p].rdata;
        end
      end
      if (mem_req.valid) begin
        issued_src[int'(mem_req.src)]++;
        if (int'(mem_req.src) < NUM_PORTS) begin
          total_core_issued++;
        end else begin
          pf_last_addr  = mem_req.addr;
          pf_last_write = mem_req.write;
        end
        credit_due.push_back(cyc + rand_delay());
        if (mem_req.write) begin
          mem_model[mem_req.addr] = mem_req.wdata;
        end else begin
          entry.valid = 1'b1;
          entry.src   = mem_req.src;
          entry.rdata = mem_model.exists(mem_req.addr) ? mem_model[mem_req.addr] : 32'h0;
          rsp_q.push_back(entry);
          rsp_due.push_back(cyc + rand_delay());
        end
      end
      mem_credit = 1'b0;
      if (!hold_credits && credit_due.size() != 0 && credit_due[0] <= cyc) begin
        mem_credit = 1'b1;
        void'(credit_due.pop_front());
      end
      mem_rsp = '0;
      if (rsp_q.size() != 0 && rsp_due[0] <= cyc) begin
        mem_rsp = rsp_q.pop_front();
        void'(rsp_due.pop_front());
      end
    end
  end

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic raise_timeout(input string what);
    timeout_what = what;
    timed_out    = 1'b1;
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s %s expected %h actual %h", test, what, exp, act);
      errors++;
    end
  endtask

  task automatic send_op(input int i);
    int p;
    int waited;
    p = op_port[i];
    waited = 0;
    while (credits[p] == 0) begin
      step();
      waited++;
      if (waited > WAIT_LIMIT) raise_timeout("a core credit");
    end
    core_req[p].valid = 1'b1;
    core_req[p].write = (op_write[i] != 0);
    core_req[p].addr  = op_addr[i];
    core_req[p].wdata = op_data[i];
    credits[p]--;
    sent[p]++;
    total_sent++;
    if (op_write[i] == 0) begin
      exp_reads[p]++;
      exp_last[p] = op_exp[i];
    end
    step();
    core_req[p].valid = 1'b0;
  endtask

  // All core requests issued and every memory response and credit returned
  task automatic wait_idle();
    int waited;
    waited = 0;
    while (!(total_core_issued == total_sent && rsp_q.size() == 0
             && credit_due.size() == 0)) begin
      step();
      waited++;
      if (waited > WAIT_LIMIT) raise_timeout("the fabric to drain");
    end
    step();
    step();  // Last response through the port register
  endtask

  task automatic expect_nothing();
    for (int p = 0; p < NUM_PORTS; p++) begin
      rsp_base[p]  = rsp_cnt[p];
      exp_reads[p] = 0;
      exp_last[p]  = '0;
    end
  endtask

  task automatic check_responses(input string test);
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_value(test, $sformatf("port %0d response count", p),
                  32'(exp_reads[p]), 32'(rsp_cnt[p] - rsp_base[p]));
      if (exp_reads[p] > 0) begin
        check_value(test, $sformatf("port %0d read data", p), exp_last[p], last_rsp[p]);
      end
    end
  endtask

  task automatic check_stamps_and_credits(input string test);
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_value(test, $sformatf("requests with src %0d", p),
                  32'(sent[p]), 32'(issued_src[p]));
      check_value(test, $sformatf("port %0d core credits", p),
                  32'(PORT_DEPTH), 32'(credits[p]));
    end
  endtask

  task automatic run_sequence(input int first, input int last);
    for (int k = first; k <= last; k++) begin
      expect_nothing();
      send_op(k);
      wait_idle();
      check_responses(op_name[k]);
    end
  endtask

  task automatic run_burst(input int first, input int last);
    int p;
    int pulses0;
    p = op_port[first];
    pulses0 = credit_pulses[p];
    expect_nothing();
    for (int k = first; k <= last; k++) send_op(k);
    wait_idle();
    check_responses(op_name[first]);
    check_value(op_name[first], "credit pulses", 32'(last - first + 1),
                32'(credit_pulses[p] - pulses0));
  endtask

  task automatic run_credit_hold(input int first, input int last);
    int issued0;
    hold_credits = 1'b1;
    issued0 = total_core_issued;
    expect_nothing();
    for (int k = first; k <= last; k++) send_op(k);
    for (int c = 0; c < HOLD_WINDOW; c++) step();
    if (total_core_issued - issued0 > MEM_CREDITS) begin
      $display("ERROR %s issued while credits withheld expected at most %0d actual %0d",
               op_name[first], MEM_CREDITS, total_core_issued - issued0);
      errors++;
    end
    hold_credits = 1'b0;
    wait_idle();
    check_value(op_name[first], "issued after release", 32'(last - first + 1),
                32'(total_core_issued - issued0));
    check_responses(op_name[first]);
  endtask

  task automatic run_prefetch(input int i, input bit enable);
    logic [31:0] base;
    logic [31:0] stride;
    logic [15:0] count0;
    int          pf_issued0;
    int          waited;
    base   = op_addr[i];
    stride = op_data[i];
    pf_cfg.base_set   = 1'b1;
    pf_cfg.base       = base;
    pf_cfg.stride_set = 1'b1;
    pf_cfg.stride     = stride;
    pf_cfg.enable     = enable;
    step();
    pf_cfg.base_set   = 1'b0;
    pf_cfg.stride_set = 1'b0;
    check_value(op_name[i], "pf_stride", stride, pf_stride);
    count0     = pf_count;
    pf_issued0 = issued_src[PF_SRC];
    expect_nothing();
    send_op(i);
    wait_idle();
    if (enable) begin
      waited = 0;
      while (issued_src[PF_SRC] == pf_issued0) begin
        step();
        waited++;
        if (waited > WAIT_LIMIT) raise_timeout("the prefetch request");
      end
      wait_idle();
      check_value(op_name[i], "prefetch address", base + stride, pf_last_addr);
      check_value(op_name[i], "prefetch write bit", 32'd0, 32'(pf_last_write));
      check_value(op_name[i], "pf_count", {16'd0, count0 + 16'd1}, {16'd0, pf_count});
      check_value(op_name[i], "pf_base", base + stride, pf_base);
    end else begin
      check_value(op_name[i], "prefetch requests", 32'(pf_issued0), 32'(issued_src[PF_SRC]));
      check_value(op_name[i], "pf_count", {16'd0, count0}, {16'd0, pf_count});
    end
    check_responses(op_name[i]);
    pf_cfg.enable = 1'b0;
  endtask

  task automatic load_ops();
    int          fd;
    string       line;
    string       nm;
    int          pt;
    int          wr;
    logic [31:0] ad;
    logic [31:0] dt;
    logic [31:0] ex;
    num_ops = 0;
    fd = $fopen("testbench/fabric_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file");
    end else begin
      while (!$feof(fd) && num_ops < MAX_OPS) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.substr(0, 0) == "#") continue;
        if ($sscanf(line, "%s %d %d %h %h %h", nm, pt, wr, ad, dt, ex) == 6) begin
          op_name[num_ops]  = nm;
          op_port[num_ops]  = pt;
          op_write[num_ops] = wr;
          op_addr[num_ops]  = ad;
          op_data[num_ops]  = dt;
          op_exp[num_ops]   = ex;
          num_ops++;
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    int i;
    int j;
    int err0;
    rst_ni     = 1'b0;
    pf_cfg     = '0;
    mem_credit = 1'b0;
    mem_rsp    = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      core_req[p] = '0;
      credits[p]  = PORT_DEPTH;
    end
    load_ops();
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    step();

    i = 0;
    while (i < num_ops) begin
      j = i;
      while (j + 1 < num_ops && op_name[j + 1] == op_name[i]) j++;
      err0 = errors;
      case (op_name[i])
        "burst":        run_burst(i, j);
        "credit_hold":  run_credit_hold(i, j);
        "prefetch":     run_prefetch(i, 1'b1);
        "prefetch_off": run_prefetch(i, 1'b0);
        default:        run_sequence(i, j);
      endcase
      check_stamps_and_credits(op_name[i]);
      tests_run++;
      if (errors != err0) begin
        tests_failed++;
        $display("Test %s: fail", op_name[i]);
      end else begin
        $display("Test %s: pass", op_name[i]);
      end
      i = j + 1;
    end

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_run > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Overall limit, and the end of the run when a wait loop gives up
  initial begin
    int guard_cycles;
    guard_cycles = 0;
    while (!timed_out && guard_cycles < SIM_CYCLES) begin
      @(posedge clk_i);
      guard_cycles++;
    end
    if (timed_out) begin
      $display("Timeout while waiting for %s", timeout_what);
    end else begin
      $display("Simulation time limit reached");
    end
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
